//--- dlc_pkg.sv
`default_nettype none

package dlc_pkg;

  localparam int DATA_W     = 16;  // Sample and packet width
  localparam int FIFO_DEPTH = 4;   // Entries in each FIFO

  // Raw input sample, two's complement
  typedef logic signed [DATA_W-1:0] sample_t;
  // Quantized level or signed level difference
  typedef logic signed [DATA_W-1:0] lvl_t;
  // Unsigned magnitude, also used for remainders and sample counts
  typedef logic [DATA_W-1:0] mag_t;
  typedef logic [DATA_W-1:0] pkt_t;  // Packed dt | dir | dlvl word
  typedef logic [3:0] shift_t;       // Shift amounts and field widths

  // Controller FSM
  typedef enum logic [1:0] {
    ST_RUN,       // Popping samples, normal packets
    ST_DLVL_OVF,  // Splitting a large delta level
    ST_DT_OVF     // Sending a time-only packet
  } dlc_state_e;

endpackage

`default_nettype wire

//--- dlc_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module dlc_fifo #(
  parameter int DEPTH = dlc_pkg::FIFO_DEPTH  // Power of two, 2 or more
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          push_i,
  input  dlc_pkg::pkt_t data_i,
  input  logic          pop_i,
  output dlc_pkg::pkt_t data_o,
  output logic          full_o,
  output logic          empty_o
);

  localparam int AW = $clog2(DEPTH);

  logic [AW-1:0] wr_ptr_q;  // Next free slot
  logic [AW-1:0] rd_ptr_q;  // Head slot
  logic [AW:0]   count_q;   // Extra bit tells full from empty
  logic          do_push;
  logic          do_pop;

  dlc_pkg::pkt_t mem_q [DEPTH];

  assign full_o  = (count_q == (AW+1)'(DEPTH));
  assign empty_o = (count_q == '0);

  // Requests against full or empty are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign data_o = mem_q[rd_ptr_q];  // Registered head, no fall-through

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps on power of two
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- dlc_level_xing.sv
`timescale 1ns/10ps
`default_nettype none

module dlc_level_xing (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  dlc_pkg::sample_t sample_i,        // Input FIFO head
  input  logic             sample_valid_i,  // Head popped this cycle
  input  dlc_pkg::shift_t  cfg_log_wl_i,    // log2 of level width
  output logic             xing_o,
  output dlc_pkg::mag_t    dlvl_mag_o,
  output logic             dir_o            // 1 when level fell
);

  dlc_pkg::lvl_t din_lvl;     // Level of the head sample
  dlc_pkg::lvl_t curr_lvl_q;  // Level of the last crossing

  // One bit wider than a level, extreme levels cannot wrap
  logic signed [dlc_pkg::DATA_W:0] dlvl;

  // Arithmetic shift keeps negative samples on negative levels
  assign din_lvl = sample_i >>> cfg_log_wl_i;

  // Signed operands, sign-extended into the wide result
  assign dlvl = din_lvl - curr_lvl_q;

  // Sign-magnitude split
  assign dir_o      = dlvl[dlc_pkg::DATA_W];
  assign dlvl_mag_o = dlc_pkg::mag_t'(dir_o ? -dlvl : dlvl);  // Fits, max is 2^16-1

  // Crossing only on a consumed sample
  assign xing_o = sample_valid_i && (dlvl != '0);

  // Track the new level at each crossing
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      curr_lvl_q <= '0;  // Start on level zero
    end else if (xing_o) begin
      curr_lvl_q <= din_lvl;
    end
  end

endmodule

`default_nettype wire

//--- dlc_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module dlc_ctrl (
  input  logic            clk_i,
  input  logic            rst_ni,
  // Input FIFO side
  input  logic            in_empty_i,
  output logic            pop_o,
  // From level unit
  input  logic            xing_i,      // Already qualified by pop
  input  dlc_pkg::mag_t   dlvl_mag_i,
  input  logic            dir_i,
  // Output FIFO side
  input  logic            out_full_i,
  output logic            push_o,
  output dlc_pkg::pkt_t   pkt_o,
  // Config
  input  dlc_pkg::shift_t cfg_dlvl_bits_i,
  // Interrupt
  input  logic            intr_clr_i,
  output logic            xing_intr_o
);

  dlc_pkg::dlc_state_e state_q;
  dlc_pkg::dlc_state_e state_d;

  dlc_pkg::mag_t dlvl_max;    // All ones in the delta-level field
  dlc_pkg::mag_t dt_max;      // All ones in the delta-time field
  logic [4:0]    dt_shift;    // Delta-time field offset

  dlc_pkg::mag_t dt_cnt_q;    // Samples since last packet
  dlc_pkg::mag_t dt_cnt_inc;  // Count including the popped sample
  logic          dt_ovf;      // Count hit the field limit, no crossing

  dlc_pkg::mag_t rem_q;       // Delta level still to be sent
  dlc_pkg::mag_t rem_first;   // Remainder after the first chunk
  dlc_pkg::mag_t rem_next;    // Remainder after one more chunk
  logic          rem_big;     // Remainder needs another full chunk
  logic          dir_q;       // Direction of the split crossing
  logic          dlvl_ovf;    // Crossing too large for one packet

  dlc_pkg::mag_t pkt_dt;      // Packet field values before packing
  dlc_pkg::mag_t pkt_dlvl;
  logic          pkt_dir;

  // Field limits from the configured delta-level width
  assign dlvl_max = ~({dlc_pkg::DATA_W{1'b1}} << cfg_dlvl_bits_i);
  assign dt_shift = {1'b0, cfg_dlvl_bits_i} + 5'd1;  // Skip the direction bit
  assign dt_max   = {dlc_pkg::DATA_W{1'b1}} >> dt_shift;

  // Own incrementer and subtractors
  assign dt_cnt_inc = dt_cnt_q + 1'b1;
  assign rem_first  = dlvl_mag_i - dlvl_max;
  assign rem_next   = rem_q - dlvl_max;

  assign dlvl_ovf = xing_i && (dlvl_mag_i > dlvl_max);
  assign rem_big  = (rem_q > dlvl_max);
  assign dt_ovf   = pop_o && !xing_i && (dt_cnt_inc == dt_max);

  // Pop only in RUN with room for a packet
  assign pop_o = (state_q == dlc_pkg::ST_RUN) && !in_empty_i && !out_full_i;

  // Push and field selection per state
  always_comb begin
    push_o   = 1'b0;
    pkt_dt   = '0;
    pkt_dlvl = '0;
    pkt_dir  = 1'b0;
    case (state_q)
      dlc_pkg::ST_RUN: begin
        push_o   = xing_i;  // Normal packet or first chunk
        pkt_dt   = dt_cnt_inc;
        pkt_dlvl = dlvl_ovf ? dlvl_max : dlvl_mag_i;
        pkt_dir  = dir_i;
      end
      dlc_pkg::ST_DLVL_OVF: begin
        push_o   = !out_full_i;
        pkt_dlvl = rem_big ? dlvl_max : rem_q;  // Chunks follow with dt 0
        pkt_dir  = dir_q;
      end
      dlc_pkg::ST_DT_OVF: begin
        push_o = !out_full_i;
        pkt_dt = dt_max;  // Time-only packet
      end
      default: begin
        push_o = 1'b0;
      end
    endcase
  end

  // dt | dir | dlvl, dt loses any bits shifted past the top
  assign pkt_o = (pkt_dt << dt_shift)
               | (dlc_pkg::mag_t'(pkt_dir) << cfg_dlvl_bits_i)
               | (pkt_dlvl & dlvl_max);

  // Next state, everything holds while the output FIFO is full
  always_comb begin
    state_d = state_q;
    case (state_q)
      dlc_pkg::ST_RUN: begin
        if (dlvl_ovf)    state_d = dlc_pkg::ST_DLVL_OVF;
        else if (dt_ovf) state_d = dlc_pkg::ST_DT_OVF;
      end
      dlc_pkg::ST_DLVL_OVF: begin
        if (!out_full_i && !rem_big) state_d = dlc_pkg::ST_RUN;  // Last chunk sent
      end
      dlc_pkg::ST_DT_OVF: begin
        if (!out_full_i) state_d = dlc_pkg::ST_RUN;
      end
      default: state_d = dlc_pkg::ST_RUN;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= dlc_pkg::ST_RUN;
      dt_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (pop_o) begin
        // Restart after any packet group
        dt_cnt_q <= (xing_i || dt_ovf) ? '0 : dt_cnt_inc;
      end
    end
  end

  // Overflow remainder and its direction
  always_ff @(posedge clk_i) begin
    if (pop_o && dlvl_ovf) begin
      rem_q <= rem_first;
      dir_q <= dir_i;
    end else if (state_q == dlc_pkg::ST_DLVL_OVF && !out_full_i) begin
      rem_q <= rem_next;
    end
  end

  // Sticky interrupt, a new crossing wins over clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      xing_intr_o <= 1'b0;
    end else if (xing_i) begin
      xing_intr_o <= 1'b1;
    end else if (intr_clr_i) begin
      xing_intr_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- dlc_top.sv
`timescale 1ns/10ps
`default_nettype none

module dlc_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Sample input port
  input  logic             in_push_i,
  input  dlc_pkg::sample_t in_data_i,
  output logic             in_full_o,
  // Packet output port
  input  logic             out_pop_i,
  output dlc_pkg::pkt_t    out_data_o,
  output logic             out_empty_o,
  // Static config
  input  dlc_pkg::shift_t  cfg_log_wl_i,
  input  dlc_pkg::shift_t  cfg_dlvl_bits_i,
  // Interrupt
  input  logic             intr_clr_i,
  output logic             xing_intr_o
);

  dlc_pkg::sample_t fifo_data;  // Input FIFO head
  logic             in_empty;
  logic             pop;        // Also marks the head as a valid sample
  logic             xing;
  dlc_pkg::mag_t    dlvl_mag;
  logic             dir;
  logic             out_full;
  logic             push;
  dlc_pkg::pkt_t    pkt;

  // Sample buffer
  dlc_fifo #(
    .DEPTH (dlc_pkg::FIFO_DEPTH)
  ) in_fifo_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (in_push_i),
    .data_i  (in_data_i),
    .pop_i   (pop),
    .data_o  (fifo_data),
    .full_o  (in_full_o),
    .empty_o (in_empty)
  );

  dlc_level_xing level_xing_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .sample_i       (fifo_data),
    .sample_valid_i (pop),
    .cfg_log_wl_i   (cfg_log_wl_i),
    .xing_o         (xing),
    .dlvl_mag_o     (dlvl_mag),
    .dir_o          (dir)
  );

  dlc_ctrl ctrl_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .in_empty_i      (in_empty),
    .pop_o           (pop),
    .xing_i          (xing),
    .dlvl_mag_i      (dlvl_mag),
    .dir_i           (dir),
    .out_full_i      (out_full),
    .push_o          (push),
    .pkt_o           (pkt),
    .cfg_dlvl_bits_i (cfg_dlvl_bits_i),
    .intr_clr_i      (intr_clr_i),
    .xing_intr_o     (xing_intr_o)
  );

  // Packet buffer
  dlc_fifo #(
    .DEPTH (dlc_pkg::FIFO_DEPTH)
  ) out_fifo_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (push),
    .data_i  (pkt),
    .pop_i   (out_pop_i),
    .data_o  (out_data_o),
    .full_o  (out_full),
    .empty_o (out_empty_o)
  );

endmodule

`default_nettype wire

//--- dlc_checker.sv
`timescale 1ns/10ps
`default_nettype none

module dlc_checker (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Sample port as seen at the DUT
  input  logic             in_push_i,
  input  dlc_pkg::sample_t in_data_i,
  input  logic             in_full_i,
  // Packet port as seen at the DUT
  input  logic             out_pop_i,
  input  dlc_pkg::pkt_t    out_data_i,
  input  logic             out_empty_i,
  input  dlc_pkg::shift_t  cfg_log_wl_i,
  input  dlc_pkg::shift_t  cfg_dlvl_bits_i,
  output int               err_cnt_o,
  output int               pkt_cnt_o,
  output int               pending_o
);

  dlc_pkg::pkt_t exp_q[$];    // Expected packets in order
  dlc_pkg::pkt_t exp_pkt;
  int            curr_lvl;    // Model level after the last crossing
  int            dt_cnt;      // Model samples since the last packet
  int            err_cnt = 0;
  int            pkt_cnt = 0;

  // dt above dir above delta level
  function automatic dlc_pkg::pkt_t pack_pkt(input int dt, input bit dir, input int dlvl);
    int bits;
    int word;
    bits = int'(cfg_dlvl_bits_i);
    word = (dt << (bits + 1)) | (int'(dir) << bits) | dlvl;
    return dlc_pkg::pkt_t'(word);
  endfunction

  // Expected packets for one accepted sample
  function automatic void ref_sample(input dlc_pkg::sample_t s);
    int lvl;
    int delta;
    int mag;
    int dt;
    int dlvl_max;
    int dt_max;
    bit dir;
    dlvl_max = (1 << int'(cfg_dlvl_bits_i)) - 1;
    dt_max   = (1 << (dlc_pkg::DATA_W - 1 - int'(cfg_dlvl_bits_i))) - 1;
    lvl      = int'(s) >>> int'(cfg_log_wl_i);  // Floor toward minus infinity
    dt_cnt++;
    if (lvl != curr_lvl) begin
      delta    = lvl - curr_lvl;
      dir      = (delta < 0);  // Level fell
      mag      = dir ? -delta : delta;
      curr_lvl = lvl;
      dt       = dt_cnt;
      while (mag > dlvl_max) begin
        exp_q.push_back(pack_pkt(dt, dir, dlvl_max));
        dt   = 0;  // Only the first packet of a group carries time
        mag -= dlvl_max;
      end
      exp_q.push_back(pack_pkt(dt, dir, mag));
      dt_cnt = 0;
    end else if (dt_cnt == dt_max) begin
      exp_q.push_back(pack_pkt(dt_max, 1'b0, 0));  // Time only
      dt_cnt = 0;
    end
  endfunction

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      if (exp_q.size() != 0) begin
        $display("%0t: %0d expected packets were still outstanding at reset",
                 $time, exp_q.size());
        err_cnt++;
      end
      exp_q.delete();
      curr_lvl = 0;
      dt_cnt   = 0;
    end else begin
      if (in_push_i && !in_full_i) ref_sample(in_data_i);  // Accepted sample
      if (out_pop_i && !out_empty_i) begin
        if (exp_q.size() == 0) begin
          $display("%0t: packet 0x%04h came out but none was expected", $time, out_data_i);
          err_cnt++;
        end else begin
          exp_pkt = exp_q.pop_front();
          pkt_cnt++;
          if (out_data_i !== exp_pkt) begin
            $display("[ERROR] %0t out_data_o expected 0x%04h actual 0x%04h",
                     $time, exp_pkt, out_data_i);
            err_cnt++;
          end
        end
      end
    end
    err_cnt_o <= err_cnt;
    pkt_cnt_o <= pkt_cnt;
    pending_o <= exp_q.size();
  end

endmodule

`default_nettype wire

//--- dlc_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module dlc_asserts (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       in_empty_i,
  input logic       pop_i,
  input logic       out_full_i,
  input logic       push_i,
  input logic       intr_clr_i,
  input logic       xing_intr_i,
  input logic [1:0] state_i
);

  // Output FIFO never sees a dropped push
  push_on_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_full_i |-> !push_i) else $error("push while output FIFO full");

  pop_on_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_empty_i |-> !pop_i) else $error("pop while input FIFO empty");

  // Sticky flag only drops after a clear request
  intr_fall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(xing_intr_i) |-> $past(intr_clr_i)) else $error("interrupt fell without clear");

  state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i inside {dlc_pkg::ST_RUN, dlc_pkg::ST_DLVL_OVF, dlc_pkg::ST_DT_OVF})
    else $error("FSM in unknown state");

endmodule

bind dlc_ctrl dlc_asserts asserts_i (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .in_empty_i  (in_empty_i),
  .pop_i       (pop_o),
  .out_full_i  (out_full_i),
  .push_i      (push_o),
  .intr_clr_i  (intr_clr_i),
  .xing_intr_i (xing_intr_o),
  .state_i     (state_q)
);

`default_nettype wire

//--- tb_dlc.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dlc;

  localparam int N_SLOW      = 60;   // Small steps, one crossing at a time
  localparam int N_JUMP      = 30;   // Wide jumps, split packets
  localparam int N_CONST     = 24;   // Held input after the first crossing
  localparam int N_RAND      = 120;  // Mixed stream against a slow drain
  localparam int N_TOTAL     = N_SLOW + N_JUMP + 1 + N_CONST + N_RAND;
  localparam int CYCLE_LIMIT = 40 * N_TOTAL + 200;

  logic             clk_i;
  logic             rst_ni;
  logic             in_push_i;
  dlc_pkg::sample_t in_data_i;
  logic             in_full_o;
  logic             out_pop_i;
  dlc_pkg::pkt_t    out_data_o;
  logic             out_empty_o;
  dlc_pkg::shift_t  cfg_log_wl_i;
  dlc_pkg::shift_t  cfg_dlvl_bits_i;
  logic             intr_clr_i;
  logic             xing_intr_o;

  int   sample_seed = 13644;  // Stimulus values and gaps
  int   pop_seed    = 13644;  // Drain gaps, own stream
  logic slow_drain;           // 1 pops about one cycle in three
  int   tb_errs;
  int   chk_errs;
  int   chk_pkts;
  int   pending;              // Packets the checker still waits for

  dlc_top dlc_top_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .in_push_i       (in_push_i),
    .in_data_i       (in_data_i),
    .in_full_o       (in_full_o),
    .out_pop_i       (out_pop_i),
    .out_data_o      (out_data_o),
    .out_empty_o     (out_empty_o),
    .cfg_log_wl_i    (cfg_log_wl_i),
    .cfg_dlvl_bits_i (cfg_dlvl_bits_i),
    .intr_clr_i      (intr_clr_i),
    .xing_intr_o     (xing_intr_o)
  );

  dlc_checker checker_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .in_push_i       (in_push_i),
    .in_data_i       (in_data_i),
    .in_full_i       (in_full_o),
    .out_pop_i       (out_pop_i),
    .out_data_i      (out_data_o),
    .out_empty_i     (out_empty_o),
    .cfg_log_wl_i    (cfg_log_wl_i),
    .cfg_dlvl_bits_i (cfg_dlvl_bits_i),
    .err_cnt_o       (chk_errs),
    .pkt_cnt_o       (chk_pkts),
    .pending_o       (pending)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns period
  end

  // Packet sink
  always @(posedge clk_i) begin
    if (slow_drain) begin
      out_pop_i <= (($unsigned($random(pop_seed)) % 3) == 0);
    end else begin
      out_pop_i <= 1'b1;
    end
  end

  // Watchdog
  initial begin
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, %0d expected packets never came out", cycles, pending);
    $display("SOME TESTS FAILED");
    $finish;
  end

  task automatic apply_reset();
    rst_ni <= 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
  endtask

  // Holds the sample until the input FIFO takes it
  task automatic send_sample(input int s);
    in_data_i <= dlc_pkg::sample_t'(s);
    in_push_i <= 1'b1;
    @(posedge clk_i);
    while (in_full_o) @(posedge clk_i);
    in_push_i <= 1'b0;  // Overridden by a back-to-back send
  endtask

  // Nothing pending and nothing buffered for a while
  task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < 8) begin
      @(posedge clk_i);
      if (out_empty_o && pending == 0) quiet++;
      else quiet = 0;
    end
  endtask

  task automatic check_intr(input logic exp);
    if (xing_intr_o !== exp) begin
      $display("[ERROR] %0t xing_intr_o expected %0b actual %0b", $time, exp, xing_intr_o);
      tb_errs++;
    end
  endtask

  initial begin
    int level;
    int sel;
    rst_ni          = 1'b0;
    in_push_i       = 1'b0;
    in_data_i       = '0;
    out_pop_i       = 1'b0;
    cfg_log_wl_i    = 4'd4;
    cfg_dlvl_bits_i = 4'd4;
    intr_clr_i      = 1'b0;
    slow_drain      = 1'b0;
    tb_errs         = 0;

    // Slow walk, level width 16
    apply_reset();
    level = 0;
    for (int i = 0; i < N_SLOW; i++) begin
      level += $random(sample_seed) % 25;
      send_sample(level);
    end
    wait_idle();

    // Jumps split over 3-bit delta fields
    cfg_log_wl_i    <= 4'd2;
    cfg_dlvl_bits_i <= 4'd3;
    apply_reset();
    for (int i = 0; i < N_JUMP; i++) begin
      send_sample($random(sample_seed) % 256);
    end
    wait_idle();

    // One crossing, then a held input, delta-time max of 7
    cfg_log_wl_i    <= 4'd0;
    cfg_dlvl_bits_i <= 4'd12;
    apply_reset();
    send_sample(100);
    wait_idle();
    check_intr(1'b1);
    intr_clr_i <= 1'b1;
    @(posedge clk_i);
    intr_clr_i <= 1'b0;
    @(posedge clk_i);
    check_intr(1'b0);
    for (int i = 0; i < N_CONST; i++) begin
      send_sample(100);  // Same level, no crossing
      check_intr(1'b0);
    end
    wait_idle();
    check_intr(1'b0);

    // Mixed stream with input gaps and a slow sink
    cfg_log_wl_i    <= 4'd3;
    cfg_dlvl_bits_i <= 4'd5;
    slow_drain      <= 1'b1;
    apply_reset();
    level = 0;
    for (int i = 0; i < N_RAND; i++) begin
      sel = $unsigned($random(sample_seed)) % 8;
      if (sel == 0) level += $random(sample_seed) % 1024;  // Occasional big jump
      else if (sel > 2) level += $random(sample_seed) % 64;
      if (level > 30000) level = 30000;
      if (level < -30000) level = -30000;
      send_sample(level);  // sel 1 and 2 repeat the last value
      if (sel == 7) begin
        repeat (1 + $unsigned($random(sample_seed)) % 3) @(posedge clk_i);
      end
    end
    wait_idle();

    $display("Checker errors: %0d, testbench errors: %0d, packets compared: %0d",
             chk_errs, tb_errs, chk_pkts);
    if (chk_errs == 0 && tb_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
dlc_pkg.sv
dlc_fifo.sv
dlc_level_xing.sv
dlc_ctrl.sv
dlc_top.sv
dlc_checker.sv
dlc_asserts.sv
tb_dlc.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the level-crossing encoder testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dlc -f filelist.f -o Vtb_dlc
./obj_dir/Vtb_dlc | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation result: pass"
else
  echo "Simulation result: fail"
  exit 1
fi
